// File: common/bp_macros.svh
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// ======================================================================
// Predictor sizing
// ======================================================================

// Address and data path width
`define BP_XLEN 32

// Global history length in bits
`define BP_GHR_SIZE 8

// Entries in each of gshare, bimodal and choice tables
`define BP_PHT_SIZE 256

// Direct-mapped BTB entries
`define BP_BTB_SIZE 64

// ======================================================================
// RV32 major opcodes seen by the predictor
// ======================================================================
`define BP_OP_BRANCH 7'b1100011
`define BP_OP_JAL 7'b1101111

`endif

// File: common/bp_pkg.sv
`default_nettype none

`include "bp_macros.svh"

package bp_pkg;

  // ======================================================================
  // Basic scalar types
  // ======================================================================
  typedef logic [`BP_XLEN-1:0] addr_t;

  // Speculative and committed history share this type
  typedef logic [`BP_GHR_SIZE-1:0] ghr_t;

  // 2-bit saturating counter, MSB is the taken vote
  typedef logic [1:0] ctr_t;

  // Reset value for every counter
  // For the choice table this also means "prefer gshare"
  localparam ctr_t CTR_WEAK_TAKEN = 2'b10;

  // Kind of speculation carried with a prediction
  typedef enum logic [1:0] {
    NO_SPEC = 2'b00,
    JUMP    = 2'b01,
    BRANCH  = 2'b10
  } spec_e;

  // ======================================================================
  // Bundles crossing module boundaries
  // ======================================================================

  // Fetch-side prediction
  typedef struct packed {
    addr_t pc;
    logic  taken;
    spec_e spectype;
  } bp_predict_t;

  // Execute-side feedback
  typedef struct packed {
    logic  valid;
    // Conditional branch that was predicted as BRANCH
    logic  is_cond;
    // Actual outcome
    logic  taken;
    logic  mispredict;
    addr_t pc;
    addr_t target;
  } bp_resolve_t;

  // Decoded control-flow info of the fetched word
  typedef struct packed {
    logic  is_jal;
    logic  is_branch;
    addr_t imm;
  } decode_t;

endpackage

`default_nettype wire

// File: hw/bp_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_macros.svh"

// Light pre-decode of the fetched word
// Only JAL and conditional branches matter here, JALR falls through
module bp_decode (
  input  wire logic [31:0]     inst_i,
  output bp_pkg::decode_t      dec_o
);

  logic [6:0] opcode;
  logic       is_jal;
  logic       is_branch;

  assign opcode    = inst_i[6:0];
  assign is_jal    = (opcode == `BP_OP_JAL);
  assign is_branch = (opcode == `BP_OP_BRANCH);

  // ======================================================================
  // Immediate extraction
  // ======================================================================
  always_comb begin
    dec_o.is_jal    = is_jal;
    dec_o.is_branch = is_branch;
    dec_o.imm       = '0;

    if (is_branch) begin
      // B-type, sign at bit 31, bit 0 always zero
      dec_o.imm = {{(`BP_XLEN-12){inst_i[31]}},
                   inst_i[7],
                   inst_i[30:25],
                   inst_i[11:8],
                   1'b0};
    end else if (is_jal) begin
      // J-type, 21-bit scrambled offset
      dec_o.imm = {{(`BP_XLEN-20){inst_i[31]}},
                   inst_i[19:12],
                   inst_i[20],
                   inst_i[30:21],
                   1'b0};
    end
    // Anything else keeps a zero immediate
  end

endmodule

`default_nettype wire

// File: tournament/counter_table.sv
`timescale 1ns/10ps
`default_nettype none

// Array of 2-bit saturating counters
// One async read port, one read-modify-write update port
module counter_table #(
  parameter int DEPTH = 256
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic [$clog2(DEPTH)-1:0]   rd_idx_i,
  output bp_pkg::ctr_t                    rd_ctr_o,
  input  wire logic                       upd_i,
  input  wire logic [$clog2(DEPTH)-1:0]   upd_idx_i,
  input  wire logic                       upd_taken_i,
  output bp_pkg::ctr_t                    upd_ctr_o
);

  bp_pkg::ctr_t ctr_q [DEPTH];
  bp_pkg::ctr_t upd_next;

  assign rd_ctr_o  = ctr_q[rd_idx_i];
  // Old value at the update slot, used by the choice trainer
  assign upd_ctr_o = ctr_q[upd_idx_i];

  // Saturating step toward the outcome
  always_comb begin
    upd_next = upd_ctr_o;
    if (upd_taken_i && (upd_ctr_o != 2'b11)) begin
      upd_next = upd_ctr_o + 2'd1;
    end else if (!upd_taken_i && (upd_ctr_o != 2'b00)) begin
      upd_next = upd_ctr_o - 2'd1;
    end
  end

  // Everything starts weakly taken
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        ctr_q[i] <= bp_pkg::CTR_WEAK_TAKEN;
      end
    end else if (upd_i) begin
      ctr_q[upd_idx_i] <= upd_next;
    end
  end

endmodule

`default_nettype wire

// File: tournament/tournament_dir.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_macros.svh"

// Tournament direction predictor
// A choice table arbitrates between gshare (PC ^ history) and bimodal (PC)
module tournament_dir (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                stall_i,
  input  wire bp_pkg::addr_t       pc_i,
  input  wire logic                spec_shift_i,
  input  wire logic                spec_dir_i,
  input  wire bp_pkg::bp_resolve_t resolve_i,
  output logic                     taken_o
);

  localparam int IDX_W = $clog2(`BP_PHT_SIZE);

  // ======================================================================
  // History registers and indices
  // ======================================================================
  bp_pkg::ghr_t     ghr_spec_q;
  bp_pkg::ghr_t     ghr_commit_q;
  logic [IDX_W-1:0] rd_pc_idx;
  logic [IDX_W-1:0] rd_gs_idx;
  logic [IDX_W-1:0] wr_pc_idx;
  logic [IDX_W-1:0] wr_gs_idx;
  logic             upd;
  logic             mispredict;

  bp_pkg::ctr_t     gs_rd_ctr;
  bp_pkg::ctr_t     bm_rd_ctr;
  bp_pkg::ctr_t     ch_rd_ctr;
  bp_pkg::ctr_t     gs_old_ctr;
  bp_pkg::ctr_t     bm_old_ctr;
  logic             ch_upd;
  logic             ch_toward_gs;

  // Lookups use the speculative history and training the committed one
  assign rd_pc_idx = pc_i[IDX_W+1:2];
  assign rd_gs_idx = rd_pc_idx ^ IDX_W'(ghr_spec_q);
  assign wr_pc_idx = resolve_i.pc[IDX_W+1:2];
  assign wr_gs_idx = wr_pc_idx ^ IDX_W'(ghr_commit_q);

  // Stall freezes all training
  assign upd        = resolve_i.valid && resolve_i.is_cond && !stall_i;
  assign mispredict = resolve_i.valid && resolve_i.mispredict;

  // Choice trains only on disagreement and moves toward the one that was right
  assign ch_upd       = upd && (gs_old_ctr[1] != bm_old_ctr[1]);
  assign ch_toward_gs = (gs_old_ctr[1] == resolve_i.taken);

  // Choice MSB set selects gshare
  assign taken_o = ch_rd_ctr[1] ? gs_rd_ctr[1] : bm_rd_ctr[1];

  // ======================================================================
  // Counter tables
  // ======================================================================
  counter_table #(.DEPTH(`BP_PHT_SIZE)) u_gshare (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_idx_i    (rd_gs_idx),
    .rd_ctr_o    (gs_rd_ctr),
    .upd_i       (upd),
    .upd_idx_i   (wr_gs_idx),
    .upd_taken_i (resolve_i.taken),
    .upd_ctr_o   (gs_old_ctr)
  );

  counter_table #(.DEPTH(`BP_PHT_SIZE)) u_bimodal (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_idx_i    (rd_pc_idx),
    .rd_ctr_o    (bm_rd_ctr),
    .upd_i       (upd),
    .upd_idx_i   (wr_pc_idx),
    .upd_taken_i (resolve_i.taken),
    .upd_ctr_o   (bm_old_ctr)
  );

  // Choice counter "taken" direction means toward gshare
  counter_table #(.DEPTH(`BP_PHT_SIZE)) u_choice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_idx_i    (rd_pc_idx),
    .rd_ctr_o    (ch_rd_ctr),
    .upd_i       (ch_upd),
    .upd_idx_i   (wr_pc_idx),
    .upd_taken_i (ch_toward_gs),
    .upd_ctr_o   ()
  );

  // ======================================================================
  // History update
  // ======================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ghr_commit_q <= '0;
      ghr_spec_q   <= '0;
    end else if (!stall_i) begin
      if (upd) begin
        ghr_commit_q <= {ghr_commit_q[`BP_GHR_SIZE-2:0], resolve_i.taken};
      end
      // Repair wins over the speculative shift
      if (mispredict) begin
        ghr_spec_q <= {ghr_commit_q[`BP_GHR_SIZE-2:0], resolve_i.taken};
      end else if (spec_shift_i) begin
        ghr_spec_q <= {ghr_spec_q[`BP_GHR_SIZE-2:0], spec_dir_i};
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/btb.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_macros.svh"

// Direct-mapped, tagged BTB
// Index is PC[IDX_W+1:2], tag is everything above it
module btb (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                stall_i,
  input  wire bp_pkg::addr_t       pc_i,
  input  wire bp_pkg::bp_resolve_t resolve_i,
  output logic                     hit_o,
  output bp_pkg::addr_t            target_o
);

  localparam int IDX_W = $clog2(`BP_BTB_SIZE);
  localparam int TAG_W = `BP_XLEN - IDX_W - 2;

  logic             valid_q  [`BP_BTB_SIZE];
  logic [TAG_W-1:0] tag_q    [`BP_BTB_SIZE];
  bp_pkg::addr_t    target_q [`BP_BTB_SIZE];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  logic             wr_en;

  assign rd_idx = pc_i[IDX_W+1:2];
  assign rd_tag = pc_i[`BP_XLEN-1:IDX_W+2];
  assign wr_idx = resolve_i.pc[IDX_W+1:2];
  assign wr_tag = resolve_i.pc[`BP_XLEN-1:IDX_W+2];

  // Only conditional branches allocate
  assign wr_en = resolve_i.valid && resolve_i.is_cond && !stall_i;

  // Lookup
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target_o = target_q[rd_idx];

  // Valid bits are the only state needing a clear
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < `BP_BTB_SIZE; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Tag and target payload
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= resolve_i.target;
    end
  end

endmodule

`default_nettype wire

// File: hw/branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_macros.svh"

// Fetch-stage branch predictor top
// Prediction is purely combinational on pc_i / inst_i and stored state
module branch_predictor (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                fetch_valid_i,
  input  wire logic                stall_i,
  input  wire bp_pkg::addr_t       pc_i,
  input  wire logic [31:0]         inst_i,
  input  wire bp_pkg::bp_resolve_t resolve_i,
  output bp_pkg::bp_predict_t      predict_o
);

  bp_pkg::decode_t dec;
  logic            btb_hit;
  bp_pkg::addr_t   btb_target;
  logic            dir_taken;
  bp_pkg::addr_t   pc_seq;
  bp_pkg::addr_t   pc_rel;
  logic            backward;
  logic            spec_shift;

  // ======================================================================
  // Sub-blocks
  // ======================================================================
  bp_decode u_bp_decode (
    .inst_i (inst_i),
    .dec_o  (dec)
  );

  btb u_btb (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .stall_i   (stall_i),
    .pc_i      (pc_i),
    .resolve_i (resolve_i),
    .hit_o     (btb_hit),
    .target_o  (btb_target)
  );

  // Speculative history follows the direction we actually emit
  tournament_dir u_tournament_dir (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_i),
    .pc_i         (pc_i),
    .spec_shift_i (spec_shift),
    .spec_dir_i   (predict_o.taken),
    .resolve_i    (resolve_i),
    .taken_o      (dir_taken)
  );

  assign pc_seq     = pc_i + bp_pkg::addr_t'(4);
  assign pc_rel     = pc_i + dec.imm;
  // Negative offset means loop-like backward branch
  assign backward   = dec.imm[`BP_XLEN-1];
  assign spec_shift = fetch_valid_i && !stall_i && dec.is_branch;

  // ======================================================================
  // Prediction priority
  // ======================================================================
  always_comb begin
    predict_o.pc       = pc_seq;
    predict_o.taken    = 1'b0;
    predict_o.spectype = bp_pkg::NO_SPEC;

    if (fetch_valid_i && !stall_i) begin
      if (dec.is_jal) begin
        predict_o.pc       = pc_rel;
        predict_o.taken    = 1'b1;
        predict_o.spectype = bp_pkg::JUMP;
      end else if (dec.is_branch) begin
        predict_o.spectype = bp_pkg::BRANCH;
        if (btb_hit) begin
          // Tournament decides, BTB supplies the target
          predict_o.pc    = dir_taken ? btb_target : pc_seq;
          predict_o.taken = dir_taken;
        end else if (backward) begin
          // Static BTFN fallback on BTB miss
          predict_o.pc    = pc_rel;
          predict_o.taken = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_macros.svh"

module tb_branch_predictor;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int N_DIRECTED   = 16;
  localparam int N_RANDOM     = 300;
  localparam int N_STALL      = 40;
  // Sum of all test phases plus headroom
  localparam int TEST_CYCLES  = RESET_CYCLES + 4 * N_DIRECTED + N_RANDOM + N_STALL + 8;
  localparam int TIMEOUT_NS   = (TEST_CYCLES + 50) * CLK_PERIOD;
  localparam int PHT_W        = $clog2(`BP_PHT_SIZE);
  localparam int BTB_W        = $clog2(`BP_BTB_SIZE);
  localparam int TAG_W        = `BP_XLEN - BTB_W - 2;

  logic                clk_i;
  logic                rst_ni;
  logic                fetch_valid_i;
  logic                stall_i;
  bp_pkg::addr_t       pc_i;
  logic [31:0]         inst_i;
  bp_pkg::bp_resolve_t resolve_i;
  bp_pkg::bp_predict_t predict_o;

  // ======================================================================
  // DUT and clock
  // ======================================================================
  branch_predictor u_branch_predictor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .stall_i       (stall_i),
    .pc_i          (pc_i),
    .inst_i        (inst_i),
    .resolve_i     (resolve_i),
    .predict_o     (predict_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ======================================================================
  // Reference model state
  // ======================================================================
  bp_pkg::ctr_t     m_gs     [`BP_PHT_SIZE];
  bp_pkg::ctr_t     m_bm     [`BP_PHT_SIZE];
  bp_pkg::ctr_t     m_ch     [`BP_PHT_SIZE];
  logic             m_valid  [`BP_BTB_SIZE];
  logic [TAG_W-1:0] m_tag    [`BP_BTB_SIZE];
  bp_pkg::addr_t    m_target [`BP_BTB_SIZE];
  bp_pkg::ghr_t     m_spec;
  bp_pkg::ghr_t     m_commit;
  logic [15:0]      lfsr_q;

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = rand_bits(1);
    return r[0];
  endfunction

  function automatic bp_pkg::addr_t rand_pc();
    return rand_bits(30) << 2;
  endfunction

  // Small PC pool of 8 BTB sets and 4 tags forces hits and conflicts
  function automatic bp_pkg::addr_t pool_pc();
    return 32'h0000_4000 | (rand_bits(2) << 8) | (rand_bits(3) << 2);
  endfunction

  function automatic bp_pkg::addr_t rand_branch_imm(input logic backward);
    logic [31:0] b;
    b = rand_bits(11);
    return {{19{backward}}, backward, b[10:0], 1'b0};
  endfunction

  function automatic bp_pkg::addr_t rand_jal_imm();
    logic [31:0] b;
    b = rand_bits(20);
    return {{11{b[19]}}, b[19:0], 1'b0};
  endfunction

  // RV32 B-type and J-type encoders
  function automatic logic [31:0] enc_branch(input bp_pkg::addr_t imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], `BP_OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(input bp_pkg::addr_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `BP_OP_JAL};
  endfunction

  function automatic bp_pkg::ctr_t ctr_step(input bp_pkg::ctr_t c, input logic up);
    if (up && c != 2'b11) begin
      return c + 2'd1;
    end else if (!up && c != 2'b00) begin
      return c - 2'd1;
    end
    return c;
  endfunction

  function automatic void model_reset();
    for (int i = 0; i < `BP_PHT_SIZE; i++) begin
      m_gs[i] = bp_pkg::CTR_WEAK_TAKEN;
      m_bm[i] = bp_pkg::CTR_WEAK_TAKEN;
      m_ch[i] = bp_pkg::CTR_WEAK_TAKEN;
    end
    for (int i = 0; i < `BP_BTB_SIZE; i++) begin
      m_valid[i] = 1'b0;
    end
    m_spec   = '0;
    m_commit = '0;
  endfunction

  // Expected prediction from the priority rules and model state
  function automatic bp_pkg::bp_predict_t model_predict(input logic fv, input logic st,
      input bp_pkg::addr_t pc, input logic [31:0] inst, input bp_pkg::addr_t imm);
    bp_pkg::bp_predict_t p;
    logic [PHT_W-1:0]    pidx;
    logic [BTB_W-1:0]    bidx;
    logic                hit;
    logic                dir;
    p.pc       = pc + 32'd4;
    p.taken    = 1'b0;
    p.spectype = bp_pkg::NO_SPEC;
    pidx = pc[PHT_W+1:2];
    bidx = pc[BTB_W+1:2];
    hit  = m_valid[bidx] && (m_tag[bidx] == pc[`BP_XLEN-1:BTB_W+2]);
    dir  = m_ch[pidx][1] ? m_gs[pidx ^ PHT_W'(m_spec)][1] : m_bm[pidx][1];
    if (fv && !st) begin
      if (inst[6:0] == `BP_OP_JAL) begin
        p.pc       = pc + imm;
        p.taken    = 1'b1;
        p.spectype = bp_pkg::JUMP;
      end else if (inst[6:0] == `BP_OP_BRANCH) begin
        p.spectype = bp_pkg::BRANCH;
        if (hit) begin
          p.taken = dir;
          if (dir) begin
            p.pc = m_target[bidx];
          end
        end else if (imm[`BP_XLEN-1]) begin
          p.pc    = pc + imm;
          p.taken = 1'b1;
        end
      end
    end
    return p;
  endfunction

  // State change at the edge that ends the cycle
  function automatic void model_update(input logic fv, input logic st,
      input logic [31:0] inst, input logic dir, input bp_pkg::bp_resolve_t res);
    logic [PHT_W-1:0] wi;
    logic [PHT_W-1:0] gi;
    logic [BTB_W-1:0] bi;
    logic             og;
    logic             ob;
    logic             upd;
    bp_pkg::ghr_t     old_commit;
    if (st) begin
      return;
    end
    upd        = res.valid && res.is_cond;
    old_commit = m_commit;
    if (upd) begin
      wi = res.pc[PHT_W+1:2];
      gi = wi ^ PHT_W'(old_commit);
      bi = res.pc[BTB_W+1:2];
      og = m_gs[gi][1];
      ob = m_bm[wi][1];
      m_gs[gi] = ctr_step(m_gs[gi], res.taken);
      m_bm[wi] = ctr_step(m_bm[wi], res.taken);
      // Choice trains only on disagreement
      if (og != ob) begin
        m_ch[wi] = ctr_step(m_ch[wi], og == res.taken);
      end
      m_valid[bi]  = 1'b1;
      m_tag[bi]    = res.pc[`BP_XLEN-1:BTB_W+2];
      m_target[bi] = res.target;
      m_commit     = {old_commit[`BP_GHR_SIZE-2:0], res.taken};
    end
    if (res.valid && res.mispredict) begin
      m_spec = {old_commit[`BP_GHR_SIZE-2:0], res.taken};
    end else if (fv && inst[6:0] == `BP_OP_BRANCH) begin
      m_spec = {m_spec[`BP_GHR_SIZE-2:0], dir};
    end
  endfunction

  // ======================================================================
  // Checks
  // ======================================================================
  task automatic check_predict(input bp_pkg::bp_predict_t got,
                               input bp_pkg::bp_predict_t exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s: got pc=%h taken=%b spec=%0d, expected pc=%h taken=%b spec=%0d",
               $time, msg, got.pc, got.taken, got.spectype, exp.pc, exp.taken, exp.spectype);
      $display("TEST RESULT: FAIL");
      $fatal(1, "prediction mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s: got %b, expected %b", $time, msg, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "bit mismatch");
    end
  endtask

  // One fetch and resolve cycle checked against the model
  task automatic run_cycle(input logic fv, input logic st, input bp_pkg::addr_t pc,
                           input logic [31:0] inst, input bp_pkg::addr_t imm,
                           input bp_pkg::bp_resolve_t res,
                           output bp_pkg::bp_predict_t got);
    bp_pkg::bp_predict_t exp;
    @(posedge clk_i);
    fetch_valid_i <= fv;
    stall_i       <= st;
    pc_i          <= pc;
    inst_i        <= inst;
    resolve_i     <= res;
    @(negedge clk_i);
    got = predict_o;
    exp = model_predict(fv, st, pc, inst, imm);
    check_predict(got, exp, $sformatf("fetch pc %h inst %h", pc, inst));
    model_update(fv, st, inst, exp.taken, res);
  endtask

  function automatic bp_pkg::bp_resolve_t make_resolve(input logic taken,
      input logic misp, input bp_pkg::addr_t pc, input bp_pkg::addr_t target);
    bp_pkg::bp_resolve_t r;
    r.valid      = 1'b1;
    r.is_cond    = 1'b1;
    r.taken      = taken;
    r.mispredict = misp;
    r.pc         = pc;
    r.target     = target;
    return r;
  endfunction

  // ======================================================================
  // Directed tests
  // ======================================================================
  task automatic test_sequential();
    bp_pkg::bp_predict_t got;
    bp_pkg::addr_t       pc;
    logic [31:0]         inst;
    pc = rand_pc();
    // Branch word with fetch idle must still be sequential
    run_cycle(1'b0, 1'b0, pc, enc_branch(32'hffff_fff0), 32'hffff_fff0, '0, got);
    for (int i = 0; i < N_DIRECTED / 2; i++) begin
      pc   = rand_pc();
      // OP-IMM and JALR words
      inst = (rand_bits(25) << 7) | ((i % 2) ? 32'h67 : 32'h13);
      run_cycle(1'b1, 1'b0, pc, inst, '0, '0, got);
    end
  endtask

  task automatic test_jal();
    bp_pkg::bp_predict_t got;
    bp_pkg::addr_t       imm;
    for (int i = 0; i < N_DIRECTED; i++) begin
      imm = rand_jal_imm();
      run_cycle(1'b1, 1'b0, rand_pc(), enc_jal(imm), imm, '0, got);
    end
  endtask

  task automatic test_static_branch();
    bp_pkg::bp_predict_t got;
    bp_pkg::addr_t       imm;
    for (int i = 0; i < N_DIRECTED; i++) begin
      imm = rand_branch_imm(i[0]);
      run_cycle(1'b1, 1'b0, rand_pc(), enc_branch(imm), imm, '0, got);
    end
  endtask

  task automatic test_btb_hit();
    bp_pkg::bp_predict_t got;
    bp_pkg::bp_predict_t exp;
    bp_pkg::addr_t       p;
    bp_pkg::addr_t       t;
    bp_pkg::addr_t       imm;
    p   = rand_pc();
    t   = rand_pc();
    imm = rand_branch_imm(1'b0);
    run_cycle(1'b0, 1'b0, p, 32'h13, '0, make_resolve(1'b1, 1'b0, p, t), got);
    // Only the BTB can make this forward branch taken
    run_cycle(1'b1, 1'b0, p, enc_branch(imm), imm, '0, got);
    exp.pc       = t;
    exp.taken    = 1'b1;
    exp.spectype = bp_pkg::BRANCH;
    check_predict(got, exp, "fetch after taken resolve");
  endtask

  task automatic random_cycle(input logic allow_stall);
    bp_pkg::bp_predict_t got;
    bp_pkg::bp_resolve_t res;
    bp_pkg::addr_t       pc;
    bp_pkg::addr_t       imm;
    logic                fv;
    logic                st;
    pc  = pool_pc();
    imm = rand_branch_imm(rand_bit());
    fv  = (rand_bits(3) != 0);
    st  = allow_stall && (rand_bits(2) == 0);
    res = '0;
    if (rand_bit()) begin
      res            = make_resolve(rand_bit(), (rand_bits(2) == 0), pool_pc(), rand_pc());
      res.is_cond    = (rand_bits(3) != 0);
    end
    run_cycle(fv, st, pc, enc_branch(imm), imm, res, got);
  endtask

  task automatic test_stall();
    bp_pkg::bp_predict_t got;
    bp_pkg::bp_predict_t exp;
    bp_pkg::addr_t       p;
    bp_pkg::addr_t       imm;
    // Tag lies outside the random pool so the BTB set never holds it
    p   = 32'h0002_0000 | (rand_bits(6) << 2);
    imm = rand_branch_imm(1'b0);
    run_cycle(1'b1, 1'b1, p, enc_branch(imm), imm,
              make_resolve(1'b1, 1'b1, p, rand_pc()), got);
    exp.pc       = p + 32'd4;
    exp.taken    = 1'b0;
    exp.spectype = bp_pkg::NO_SPEC;
    check_predict(got, exp, "fetch during stall");
    // Dropped resolve leaves the BTB empty for p
    run_cycle(1'b1, 1'b0, p, enc_branch(imm), imm, '0, got);
    check_bit(got.taken, 1'b0, "forward branch after stalled resolve");
    for (int i = 0; i < N_STALL; i++) begin
      random_cycle(1'b1);
    end
  endtask

  // ======================================================================
  // Main sequence and watchdog
  // ======================================================================
  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    fetch_valid_i = 1'b0;
    stall_i       = 1'b0;
    pc_i          = '0;
    inst_i        = '0;
    resolve_i     = '0;
    lfsr_q        = 16'd81;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_sequential();
    test_jal();
    test_static_branch();
    test_btb_hit();
    for (int i = 0; i < N_RANDOM; i++) begin
      random_cycle(1'b0);
    end
    test_stall();

    @(posedge clk_i);
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/bp_pkg.sv
hw/bp_decode.sv
tournament/counter_table.sv
tournament/tournament_dir.sv
hw/btb.sv
hw/branch_predictor.sv
tb/tb_branch_predictor.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  - include_dirs:
      - common
    files:
      - common/bp_pkg.sv
      - hw/bp_decode.sv
      - tournament/counter_table.sv
      - tournament/tournament_dir.sv
      - hw/btb.sv
      - hw/branch_predictor.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_branch_predictor.sv
